// File: design/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address split as tag | index | byte offset
`define IC_TAG_WIDTH     20
`define IC_INDEX_WIDTH   7

// byte offset within a line, at least 3 so a line holds two words or more
`define IC_OFFSET_WIDTH  5

// associativity is tied to the 3-bit plru tree
`define IC_WAY_NUM       4

// words per line
`define IC_LINE_WORDS    (1 << (`IC_OFFSET_WIDTH - 2))

`endif

// File: design/icache_pkg.sv
`default_nettype none
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;    // instruction or data word

    typedef logic [`IC_TAG_WIDTH-1:0]     tag_t;
    typedef logic [`IC_INDEX_WIDTH-1:0]   index_t;
    typedef logic [1:0]                   way_t;
    typedef logic [`IC_OFFSET_WIDTH-3:0]  word_sel_t;   // word within a line

    // controller states
    typedef enum logic [1:0] {
        idle          = 2'b00,
        hit_judge     = 2'b01,
        load_memory   = 2'b11,
        no_cache_load = 2'b10
    } icache_state_t;

endpackage

`default_nettype wire

// File: design/icache_sdp_ram.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_defs.svh"

// one write port, one registered read port, both on clk
module icache_sdp_ram
    import icache_pkg::*;
#(
    parameter type entry_t = word_t
) (
    input  wire         clk,
    input  wire         we,
    input  wire index_t waddr,
    input  wire entry_t wdata,
    input  wire         re,
    input  wire index_t raddr,
    output entry_t      rdata
);

    localparam int SET_NUM = 1 << `IC_INDEX_WIDTH;

    entry_t mem [SET_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // output holds while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: design/plru_tree.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_defs.svh"

module plru_tree
    import icache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire index_t index,
    input  wire         update,
    input  wire way_t   visit_way,
    output way_t        victim_way
);

    localparam int SET_NUM = 1 << `IC_INDEX_WIDTH;

    // bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3
    logic [2:0] lru_bits [SET_NUM];
    logic [2:0] cur_bits;

    assign cur_bits = lru_bits[index];

    // root picks the half, the half bit picks the way
    assign victim_way = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_NUM; s++) begin
                lru_bits[s] <= '0;
            end
        end else if (update) begin
            lru_bits[index][0] <= ~visit_way[1];    // point at the other half
            if (visit_way[1]) begin
                lru_bits[index][2] <= ~visit_way[0];
            end else begin
                lru_bits[index][1] <= ~visit_way[0];
            end
            // the untouched half keeps its bit
        end
    end

endmodule

`default_nettype wire

// File: design/icache.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_defs.svh"

module icache
    import icache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // attribute from the tlb
    input  wire         no_cache,
    // datapath
    input  wire         inst_en,
    input  wire addr_t  pc_next,
    input  wire addr_t  pcF,
    output word_t       inst_rdata,
    output logic        stall,
    input  wire         stallF,
    // read channel toward the arbiter
    output addr_t       araddr,
    output logic [7:0]  arlen,
    output logic        arvalid,
    input  wire         arready,
    input  wire word_t  rdata,
    input  wire         rlast,
    input  wire         rvalid,
    output logic        rready
);

    localparam int WAY_NUM    = `IC_WAY_NUM;
    localparam int LINE_WORDS = `IC_LINE_WORDS;
    localparam int SET_NUM    = 1 << `IC_INDEX_WIDTH;

    tag_t      tag;
    index_t    index;
    index_t    index_next;
    word_sel_t offset;

    logic      first_cycle;     // first cycle out of reset
    logic      ram_re;
    index_t    raddr;
    tag_t      tag_way  [WAY_NUM];
    word_t     data_way [WAY_NUM][LINE_WORDS];

    logic [SET_NUM-1:0] valid_bits [WAY_NUM];
    logic [WAY_NUM-1:0] hit_mask;
    way_t               hit_way;
    logic               hit;
    logic               miss;

    icache_state_t state;
    icache_state_t state_next;
    logic          fill;
    logic          uncached;
    logic          addr_rcv;    // address phase accepted
    logic          data_back;
    logic          read_finish;
    word_sel_t     cnt;         // beat within the burst
    word_t         saved_rdata;

    way_t          victim_way;
    way_t          lru_visit;
    logic          lru_update;

    logic [WAY_NUM-1:0]                 tag_we;
    logic [WAY_NUM-1:0][LINE_WORDS-1:0] bank_we;

    assign tag        = pcF[31 -: `IC_TAG_WIDTH];
    assign index      = pcF[`IC_OFFSET_WIDTH +: `IC_INDEX_WIDTH];
    assign index_next = pc_next[`IC_OFFSET_WIDTH +: `IC_INDEX_WIDTH];
    assign offset     = pcF[2 +: `IC_OFFSET_WIDTH-2];

    // lookup against the ways that hold a valid line
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_mask[w] = valid_bits[w][index] & (tag_way[w] == tag);
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit  = inst_en & (|hit_mask);
    assign miss = inst_en & ~hit;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (!stallF) begin
                    state_next = hit_judge;
                end
            end
            hit_judge: begin
                if (inst_en && no_cache) begin
                    state_next = no_cache_load;
                end else if (miss) begin
                    state_next = load_memory;
                end else if (stallF) begin
                    state_next = idle;  // held by some other stall source
                end
            end
            load_memory, no_cache_load: begin
                if (read_finish) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    assign fill     = (state == load_memory);
    assign uncached = (state == no_cache_load);

    assign stall = ~((state == idle) || ((state == hit_judge) && hit && !no_cache) || !inst_en);

    assign inst_rdata = !inst_en           ? '0 :
                        (hit && !no_cache) ? data_way[hit_way][offset] : saved_rdata;

    // burst for a line fill, single beat when uncached
    assign arvalid     = (fill || uncached) && !addr_rcv;
    assign araddr      = uncached ? pcF : {tag, index, {`IC_OFFSET_WIDTH{1'b0}}};
    assign arlen       = uncached ? 8'd0 : 8'(LINE_WORDS - 1);
    assign rready      = addr_rcv;
    assign data_back   = addr_rcv && rvalid;
    assign read_finish = data_back && rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            first_cycle <= 1'b1;
            addr_rcv    <= 1'b0;
            cnt         <= '0;
        end else begin
            state       <= state_next;
            first_cycle <= 1'b0;
            if (read_finish) begin
                addr_rcv <= 1'b0;
            end else if (arvalid && arready) begin
                addr_rcv <= 1'b1;
            end
            if (read_finish) begin
                cnt <= '0;
            end else if (data_back) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // word the datapath asked for
    always_ff @(posedge clk) begin
        if ((fill && data_back && (cnt == offset)) || (uncached && read_finish)) begin
            saved_rdata <= rdata;
        end
    end

    assign lru_update = ((state == hit_judge) && hit && !no_cache) || (fill && read_finish);
    assign lru_visit  = fill ? victim_way : hit_way;

    plru_tree u_plru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .update     (lru_update),
        .visit_way  (lru_visit),
        .victim_way (victim_way)
    );

    // victim way takes each beat, tag goes in with the last one
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            tag_we[w] = fill && read_finish && (victim_way == way_t'(w));
            for (int b = 0; b < LINE_WORDS; b++) begin
                bank_we[w][b] = fill && data_back && (victim_way == way_t'(w))
                                && (cnt == word_sel_t'(b));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (tag_we[w]) begin
                    valid_bits[w][index] <= 1'b1;
                end
            end
        end
    end

    assign ram_re = ~stallF;
    assign raddr  = first_cycle ? index : index_next;   // pc_next not yet meaningful

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        icache_sdp_ram #(.entry_t(tag_t)) u_tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (index),
            .wdata (tag),
            .re    (ram_re),
            .raddr (raddr),
            .rdata (tag_way[w])
        );
        for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
            icache_sdp_ram #(.entry_t(word_t)) u_data_bank (
                .clk   (clk),
                .we    (bank_we[w][b]),
                .waddr (index),
                .wdata (rdata),
                .re    (ram_re),
                .raddr (raddr),
                .rdata (data_way[w][b])
            );
        end
    end

endmodule

`default_nettype wire

// File: design/axi_read_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_read_arbiter
    import icache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // instruction side
    input  wire addr_t  i_araddr,
    input  wire [7:0]   i_arlen,
    input  wire         i_arvalid,
    output logic        i_arready,
    output word_t       i_rdata,
    output logic        i_rlast,
    output logic        i_rvalid,
    input  wire         i_rready,
    // data side
    input  wire addr_t  d_araddr,
    input  wire [7:0]   d_arlen,
    input  wire         d_arvalid,
    output logic        d_arready,
    output word_t       d_rdata,
    output logic        d_rlast,
    output logic        d_rvalid,
    input  wire         d_rready,
    // toward memory
    output addr_t       m_araddr,
    output logic [7:0]  m_arlen,
    output logic        m_arvalid,
    input  wire         m_arready,
    input  wire word_t  m_rdata,
    input  wire         m_rlast,
    input  wire         m_rvalid,
    output logic        m_rready
);

    logic busy;     // transaction in flight
    logic owner;    // 1 for the data side
    logic sel;

    // data side wins when both ask at once
    assign sel = busy ? owner : d_arvalid;

    assign m_araddr  = sel ? d_araddr : i_araddr;
    assign m_arlen   = sel ? d_arlen : i_arlen;
    assign m_arvalid = !busy && (i_arvalid || d_arvalid);
    assign i_arready = !busy && !sel && m_arready;
    assign d_arready = !busy && sel && m_arready;

    // payload goes to both, valid only to the owner
    assign i_rdata  = m_rdata;
    assign i_rlast  = m_rlast;
    assign d_rdata  = m_rdata;
    assign d_rlast  = m_rlast;
    assign i_rvalid = busy && !owner && m_rvalid;
    assign d_rvalid = busy && owner && m_rvalid;
    assign m_rready = busy && (owner ? d_rready : i_rready);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (!busy) begin
            if (m_arvalid && m_arready) begin
                busy  <= 1'b1;
                owner <= sel;   // locked until the last beat
            end
        end else if (m_rvalid && m_rready && m_rlast) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // datapath
    input  wire         no_cache,
    input  wire         inst_en,
    input  wire addr_t  pc_next,
    input  wire addr_t  pcF,
    output wire word_t  inst_rdata,
    output wire         stall,
    input  wire         stallF,
    // data-side read port
    input  wire addr_t  d_araddr,
    input  wire [7:0]   d_arlen,
    input  wire         d_arvalid,
    output wire         d_arready,
    output wire word_t  d_rdata,
    output wire         d_rlast,
    output wire         d_rvalid,
    input  wire         d_rready,
    // memory read channel
    output wire addr_t  m_araddr,
    output wire [7:0]   m_arlen,
    output wire         m_arvalid,
    input  wire         m_arready,
    input  wire word_t  m_rdata,
    input  wire         m_rlast,
    input  wire         m_rvalid,
    output wire         m_rready
);

    // cache to arbiter
    wire addr_t i_araddr;
    wire [7:0]  i_arlen;
    wire        i_arvalid;
    wire        i_arready;
    wire word_t i_rdata;
    wire        i_rlast;
    wire        i_rvalid;
    wire        i_rready;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .no_cache   (no_cache),
        .inst_en    (inst_en),
        .pc_next    (pc_next),
        .pcF        (pcF),
        .inst_rdata (inst_rdata),
        .stall      (stall),
        .stallF     (stallF),
        .araddr     (i_araddr),
        .arlen      (i_arlen),
        .arvalid    (i_arvalid),
        .arready    (i_arready),
        .rdata      (i_rdata),
        .rlast      (i_rlast),
        .rvalid     (i_rvalid),
        .rready     (i_rready)
    );

    axi_read_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_araddr  (i_araddr),
        .i_arlen   (i_arlen),
        .i_arvalid (i_arvalid),
        .i_arready (i_arready),
        .i_rdata   (i_rdata),
        .i_rlast   (i_rlast),
        .i_rvalid  (i_rvalid),
        .i_rready  (i_rready),
        .d_araddr  (d_araddr),
        .d_arlen   (d_arlen),
        .d_arvalid (d_arvalid),
        .d_arready (d_arready),
        .d_rdata   (d_rdata),
        .d_rlast   (d_rlast),
        .d_rvalid  (d_rvalid),
        .d_rready  (d_rready),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rlast   (m_rlast),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// burst read slave, data derived from the word address
module axi_mem_model
    import icache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire addr_t  araddr,
    input  wire [7:0]   arlen,
    input  wire         arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rlast,
    output logic        rvalid,
    input  wire         rready
);

    int         ar_count;       // accepted address phases
    addr_t      ar_addr_log[$];
    logic [7:0] ar_len_log[$];

    logic        busy;
    addr_t       base;
    logic [7:0]  len;
    logic [7:0]  beat;
    logic [31:0] gap_rng = 32'h2847 ^ 32'h1234_5678;   // separate stream for gaps

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t word_at(input addr_t a);
        return xorshift({2'b00, a[31:2]} ^ 32'h2847);
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            ar_count <= 0;
        end else if (!busy && arvalid && arready) begin
            busy     <= 1'b1;
            base     <= araddr;
            len      <= arlen;
            beat     <= '0;
            ar_count <= ar_count + 1;
            ar_addr_log.push_back(araddr);
            ar_len_log.push_back(arlen);
        end else if (busy && rvalid && rready) begin
            beat <= beat + 1'b1;
            if (rlast) begin
                busy <= 1'b0;
            end
        end
    end

    // outputs change on the falling edge, roughly one cycle in four is a gap
    always @(negedge clk) begin
        gap_rng = xorshift(gap_rng);
        arready = !busy && (gap_rng[1:0] != 2'b00);
        rvalid  = busy && (gap_rng[3:2] != 2'b00);
        rdata   = busy ? word_at(base + 4 * beat) : '0;
        rlast   = busy && (beat == len);
    end

endmodule

`default_nettype wire

// File: testbench/tb_icache_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "icache_defs.svh"

module tb_icache_top
    import icache_pkg::*;
();

    logic       clk = 1'b0;
    logic       rst;
    logic       no_cache;
    logic       inst_en;
    logic       stallF;
    addr_t      pc_next;
    addr_t      pcF;
    wire word_t inst_rdata;
    wire        stall;
    addr_t      d_araddr;
    logic [7:0] d_arlen;
    logic       d_arvalid;
    logic       d_rready;
    wire        d_arready;
    wire word_t d_rdata;
    wire        d_rlast;
    wire        d_rvalid;
    wire addr_t m_araddr;
    wire [7:0]  m_arlen;
    wire        m_arvalid;
    wire        m_arready;
    wire word_t m_rdata;
    wire        m_rlast;
    wire        m_rvalid;
    wire        m_rready;

    logic [31:0] rng_state = 32'h2847;
    logic        d_owns;            // data side holds the current burst
    logic [2:0]  lru_ref;           // reference tree for the replacement set
    tag_t        way_tag[4];
    logic        way_valid[4];
    int          burst;
    int          seq_pos;           // position within the five-line sequence

    icache_top DUT (
        .clk(clk), .rst(rst), .no_cache(no_cache), .inst_en(inst_en),
        .pc_next(pc_next), .pcF(pcF), .inst_rdata(inst_rdata), .stall(stall),
        .stallF(stallF), .d_araddr(d_araddr), .d_arlen(d_arlen),
        .d_arvalid(d_arvalid), .d_arready(d_arready), .d_rdata(d_rdata),
        .d_rlast(d_rlast), .d_rvalid(d_rvalid), .d_rready(d_rready),
        .m_araddr(m_araddr), .m_arlen(m_arlen), .m_arvalid(m_arvalid),
        .m_arready(m_arready), .m_rdata(m_rdata), .m_rlast(m_rlast),
        .m_rvalid(m_rvalid), .m_rready(m_rready)
    );

    axi_mem_model mem (
        .clk(clk), .rst(rst), .araddr(m_araddr), .arlen(m_arlen),
        .arvalid(m_arvalid), .arready(m_arready), .rdata(m_rdata),
        .rlast(m_rlast), .rvalid(m_rvalid), .rready(m_rready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return xorshift({2'b00, a[31:2]} ^ 32'h2847);
    endfunction

    task report_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    task report_timeout(input string what);
        $display("Timed out at %0d ns waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // tree plru by the stated rule, returns 1 when the access needs a burst
    task plru_access(input tag_t t, output int miss);
        int w;
        w = -1;
        for (int i = 0; i < 4; i++) begin
            if (way_valid[i] && way_tag[i] == t) w = i;
        end
        miss = (w < 0);
        if (miss) begin
            w = lru_ref[0] ? {1'b1, lru_ref[2]} : {1'b0, lru_ref[1]};
            way_tag[w]   = t;
            way_valid[w] = 1'b1;
        end
        lru_ref[0] = (w < 2);
        if (w >= 2) lru_ref[2] = ~w[0];
        else lru_ref[1] = ~w[0];
    endtask

    // one fetch; exp_burst < 0 skips the address log check
    task fetch_word(input addr_t a, input logic nc, input int exp_burst);
        int    n0;
        int    t;
        addr_t line_base;
        n0        = mem.ar_count;
        line_base = a & ~((32'd1 << `IC_OFFSET_WIDTH) - 1);
        @(negedge clk);
        pc_next = a;
        stallF  = 1'b0;
        @(negedge clk);
        pcF      = a;
        no_cache = nc;
        #1;
        if (stall) begin
            t = 0;
            @(negedge clk);
            stallF = 1'b1;  // datapath holds while stalled
            #1;
            while (stall) begin
                t++;
                if (t > 500) report_timeout("the instruction read to finish");
                @(negedge clk);
                #1;
            end
            if (!nc) begin
                @(negedge clk);
                stallF = 1'b0;  // re-read the filled line
                @(negedge clk);
                #1;
                assert (!stall) else report_mismatch("re-read after fill did not hit");
            end
        end
        assert (inst_rdata === expected_word(a))
            else report_mismatch($sformatf("inst_rdata %h for pc %h, expected %h",
                                 inst_rdata, a, expected_word(a)));
        if (exp_burst >= 0) begin
            assert (mem.ar_count == n0 + exp_burst)
                else report_mismatch($sformatf("pc %h gave %0d address phases, expected %0d",
                                     a, mem.ar_count - n0, exp_burst));
            if (exp_burst == 1) begin
                assert (mem.ar_addr_log[$] == (nc ? a : line_base))
                    else report_mismatch($sformatf("araddr %h for pc %h", mem.ar_addr_log[$], a));
                assert (mem.ar_len_log[$] == (nc ? 8'd0 : 8'd7))
                    else report_mismatch($sformatf("arlen %0d for pc %h", mem.ar_len_log[$], a));
            end
        end
    endtask

    task data_read(input addr_t a, input logic [7:0] len);
        int t;
        int beat;
        @(negedge clk);
        d_araddr  = a;
        d_arlen   = len;
        d_arvalid = 1'b1;
        d_rready  = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > 500) report_timeout("the data-side address phase");
        end while (!d_arready);
        @(negedge clk);
        d_arvalid = 1'b0;
        beat = 0;
        t = 0;
        while (beat <= len) begin
            @(posedge clk);
            t++;
            if (t > 500) report_timeout("data-side read beats");
            if (d_rvalid) begin
                assert (d_rdata === expected_word(a + 4 * beat))
                    else report_mismatch($sformatf("d_rdata %h at %h", d_rdata, a + 4 * beat));
                assert (d_rlast == (beat == len))
                    else report_mismatch($sformatf("d_rlast wrong on beat %0d", beat));
                beat++;
            end
        end
    endtask

    // arbiter priority and beat routing
    always @(posedge clk) begin
        if (!rst) begin
            if (m_arvalid && m_arready) begin
                assert (!d_arvalid || d_arready)
                    else report_mismatch("instruction request accepted ahead of data request");
                d_owns <= d_arready;
            end
            if (m_rvalid && m_rready) begin
                assert (d_rvalid == d_owns)
                    else report_mismatch("read beat routed to the wrong master");
            end
        end
    end

    initial begin
        rst       = 1'b1;
        no_cache  = 1'b0;
        inst_en   = 1'b1;
        stallF    = 1'b1;
        pc_next   = '0;
        pcF       = '0;
        d_araddr  = '0;
        d_arlen   = '0;
        d_arvalid = 1'b0;
        d_rready  = 1'b0;
        lru_ref   = '0;
        for (int i = 0; i < 4; i++) way_valid[i] = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        fetch_word(32'h0000_1048, 1'b0, 1);         // cold miss
        for (int i = 0; i < 8; i++) begin
            if (i != 2) fetch_word(32'h0000_1040 + 4 * i, 1'b0, 0);
        end

        fetch_word(32'h0000_2124, 1'b1, 1);         // uncached single beat
        fetch_word(32'h0000_2124, 1'b0, 1);         // line still absent

        // five tags on set 5, forward then backward
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 5; k++) begin
                seq_pos = (r == 0) ? k : 4 - k;
                plru_access(tag_t'(8 + seq_pos), burst);
                fetch_word(((8 + seq_pos) << 12) | (5 << 5) | (seq_pos << 2), 1'b0, burst);
            end
        end

        // both masters ask in the same cycle
        fork
            fetch_word(32'h0000_3300, 1'b0, -1);
            begin
                @(negedge clk);
                @(negedge clk);
                data_read(32'h0000_8000, 8'd3);
            end
        join

        fork
            repeat (20) fetch_word(next_rand() & 32'h0000_3ffc, 1'b0, -1);
            repeat (10) begin
                repeat (next_rand() % 20) @(negedge clk);
                data_read(next_rand() & 32'h0000_fffc, 8'(next_rand() % 4));
            end
        join

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/icache_pkg.sv
design/icache_sdp_ram.sv
design/plru_tree.sv
design/icache.sv
design/axi_read_arbiter.sv
design/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache_top.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/icache_sdp_ram.sv
      - design/plru_tree.sv
      - design/icache.sv
      - design/axi_read_arbiter.sv
      - design/icache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/axi_mem_model.sv
      - testbench/tb_icache_top.sv
